// File: Bender.yml
package:
  name: lumi_rx

sources:
  - lumi_pkg.sv
  - lumi_rx_sampler.sv
  - lumi_rx_fifo.sv
  - lumi_rx_arbiter.sv
  - lumi_rx_assembler.sv
  - lumi_rx_credit.sv
  - lumi_rx_top.sv
  - target: simulation
    files:
      - tb_lumi_rx.sv

// File: filelist.f
lumi_pkg.sv
lumi_rx_sampler.sv
lumi_rx_fifo.sv
lumi_rx_arbiter.sv
lumi_rx_assembler.sv
lumi_rx_credit.sv
lumi_rx_top.sv
tb_lumi_rx.sv

// File: lumi_pkg.sv
// Shared widths, command enums, packet struct and decode functions for the link receiver
`default_nettype none

package lumi_pkg;

   // ##############################
   // Widths
   // ##############################
   localparam int LUMI_BEAT_W = 32;   // One link word per beat
   localparam int LUMI_CW     = 32;   // Command word
   localparam int LUMI_AW     = 32;   // Address word
   localparam int LUMI_DW     = 64;   // Two words of data
   localparam int LUMI_CRDT_W = 16;   // Credit counters

   // Credit subtypes carried in link command bits 15:8
   localparam logic [7:0] LUMI_SUB_REQ_A  = 8'h01;
   localparam logic [7:0] LUMI_SUB_REQ_B  = 8'h02;
   localparam logic [7:0] LUMI_SUB_RESP_A = 8'h11;
   localparam logic [7:0] LUMI_SUB_RESP_B = 8'h12;

   // Opcode in the low nibble of the command word
   typedef enum logic [3:0] {
      OP_READ_REQ   = 4'd1,
      OP_WRITE_REQ  = 4'd2,
      OP_POSTED_REQ = 4'd3,
      OP_READ_RESP  = 4'd4,
      OP_WRITE_RESP = 4'd5,
      OP_LINK       = 4'd6
   } lumi_opcode_e;

   typedef enum logic [1:0] {CLS_REQ, CLS_RESP, CLS_LINK, CLS_NONE} lumi_class_e;

   typedef enum logic {ARB_IDLE, ARB_BUSY} lumi_arb_state_e;

   // Word slot i of the packet sits at bits [32*i +: 32]
   typedef struct packed {
      logic [LUMI_DW-1:0] data;      // Slots 3 and 4
      logic [LUMI_AW-1:0] srcaddr;   // Slot 2
      logic [LUMI_AW-1:0] dstaddr;   // Slot 1
      logic [LUMI_CW-1:0] cmd;       // Slot 0, first beat
   } lumi_pkt_t;

   // Beats on the link for a given command word
   function automatic logic [2:0] lumi_pkt_beats(input logic [LUMI_CW-1:0] cmd);
      case (lumi_opcode_e'(cmd[3:0]))
         OP_READ_REQ, OP_WRITE_RESP:                return 3'd3;   // Header only
         OP_WRITE_REQ, OP_POSTED_REQ, OP_READ_RESP: return 3'd5;   // Header plus data
         default:                                   return 3'd1;   // Link or invalid
      endcase
   endfunction

   // Queue class for a given command word
   function automatic lumi_class_e lumi_pkt_class(input logic [LUMI_CW-1:0] cmd);
      case (lumi_opcode_e'(cmd[3:0]))
         OP_READ_REQ, OP_WRITE_REQ, OP_POSTED_REQ: return CLS_REQ;
         OP_READ_RESP, OP_WRITE_RESP:              return CLS_RESP;
         OP_LINK:                                  return CLS_LINK;
         default:                                  return CLS_NONE;   // Dropped at input
      endcase
   endfunction

endpackage

`default_nettype wire

// File: lumi_rx_arbiter.sv
// Priority arbiter that lets the three queues share the reassembly path a packet at a time
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_arbiter
   import lumi_pkg::*;
   (
      input  wire                    clk,
      input  wire                    nreset,
      input  wire                    req_empty,
      input  wire                    resp_empty,
      input  wire                    lnk_empty,
      input  wire [LUMI_BEAT_W-1:0]  req_dout,
      input  wire [LUMI_BEAT_W-1:0]  resp_dout,
      input  wire [LUMI_BEAT_W-1:0]  lnk_dout,
      input  wire                    hold,        // Assembler output stalled
      output logic                   req_rd,
      output logic                   resp_rd,
      output logic                   lnk_rd,
      output logic                   beat_rd,
      output logic [LUMI_BEAT_W-1:0] beat_data,
      output logic [2:0]             beat_idx,    // Word slot in packet
      output logic                   beat_last,
      output logic                   req_beat_rd,
      output logic                   resp_beat_rd
   );

   lumi_arb_state_e state;
   lumi_class_e     sel_q;     // Queue held for the packet
   lumi_class_e     sel;
   logic [2:0]      beats_q;
   logic [2:0]      idx_q;
   logic            sel_empty;

   // ##############################
   // Queue select
   // ##############################
   always_comb
      if (state == ARB_BUSY)
         sel = sel_q;
      else if (!lnk_empty)
         sel = CLS_LINK;   // Credits first
      else if (!resp_empty)
         sel = CLS_RESP;
      else if (!req_empty)
         sel = CLS_REQ;
      else
         sel = CLS_NONE;

   assign sel_empty = (sel == CLS_LINK) ? lnk_empty  :
                      (sel == CLS_RESP) ? resp_empty :
                      (sel == CLS_REQ)  ? req_empty  : 1'b1;

   assign beat_data = (sel == CLS_LINK) ? lnk_dout  :
                      (sel == CLS_RESP) ? resp_dout :
                      (sel == CLS_REQ)  ? req_dout  : '0;

   // ##############################
   // Beat reads
   // ##############################
   assign beat_rd = ~hold & ~sel_empty;   // One beat per cycle at most
   assign req_rd  = beat_rd & (sel == CLS_REQ);
   assign resp_rd = beat_rd & (sel == CLS_RESP);
   assign lnk_rd  = beat_rd & (sel == CLS_LINK);

   assign beat_idx  = (state == ARB_IDLE) ? 3'd0 : idx_q;
   assign beat_last = (state == ARB_IDLE) ? (lumi_pkt_beats(beat_data) == 3'd1) :
                                            (idx_q == beats_q - 3'd1);

   // Credit strobes for the local counters
   assign req_beat_rd  = req_rd;
   assign resp_beat_rd = resp_rd;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         state   <= ARB_IDLE;
         sel_q   <= CLS_NONE;
         beats_q <= 3'd0;
         idx_q   <= 3'd0;
      end
      else if (beat_rd)
      begin
         if (beat_last)
            state <= ARB_IDLE;   // Next packet may switch queue
         else
         begin
            state <= ARB_BUSY;
            idx_q <= beat_idx + 3'd1;
            if (state == ARB_IDLE)
            begin
               sel_q   <= sel;   // Lock queue for packet
               beats_q <= lumi_pkt_beats(beat_data);
            end
         end
      end

   // Queue heads start packets of their own class
   a_head_class: assert property (@(posedge clk) disable iff (!nreset)
      beat_rd && (state == ARB_IDLE) |-> (lumi_pkt_class(beat_data) == sel));

endmodule

`default_nettype wire

// File: lumi_rx_assembler.sv
// Rebuilds packets from beats and hands them to the request, response or credit path
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_assembler
   import lumi_pkg::*;
   (
      input  wire                   clk,
      input  wire                   nreset,
      input  wire                   beat_rd,
      input  wire [LUMI_BEAT_W-1:0] beat_data,
      input  wire [2:0]             beat_idx,
      input  wire                   beat_last,
      input  wire                   umi_req_out_ready,
      input  wire                   umi_resp_out_ready,
      output logic                  hold,
      output lumi_pkt_t             umi_req_out,
      output logic                  umi_req_out_valid,
      output lumi_pkt_t             umi_resp_out,
      output logic                  umi_resp_out_valid,
      output logic                  lnk_upd,     // Credit update strobe
      output logic [LUMI_CW-1:0]    lnk_cmd
   );

   localparam int PKT_W = $bits(lumi_pkt_t);

   logic [PKT_W-1:0] shift_q;     // Word-slotted packet
   logic [PKT_W-1:0] shift_nxt;
   logic             done;
   lumi_class_e      done_cls;

   // ##############################
   // Reassembly
   // ##############################
   always_comb
   begin
      shift_nxt = (beat_idx == 3'd0) ? '0 : shift_q;   // Fresh packet clears all slots
      shift_nxt[beat_idx*LUMI_BEAT_W +: LUMI_BEAT_W] = beat_data;
   end

   always_ff @(posedge clk)
      if (beat_rd)
         shift_q <= shift_nxt;

   assign done     = beat_rd & beat_last;
   assign done_cls = lumi_pkt_class(shift_nxt[LUMI_CW-1:0]);

   // Stall the arbiter while either port waits
   assign hold = (umi_req_out_valid & ~umi_req_out_ready) |
                 (umi_resp_out_valid & ~umi_resp_out_ready);

   // ##############################
   // Output split
   // ##############################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         umi_req_out_valid  <= 1'b0;
         umi_resp_out_valid <= 1'b0;
         lnk_upd            <= 1'b0;
      end
      else
      begin
         if (umi_req_out_valid & umi_req_out_ready)
            umi_req_out_valid <= 1'b0;
         if (done && (done_cls == CLS_REQ))
            umi_req_out_valid <= 1'b1;   // New packet wins over accept
         if (umi_resp_out_valid & umi_resp_out_ready)
            umi_resp_out_valid <= 1'b0;
         if (done && (done_cls == CLS_RESP))
            umi_resp_out_valid <= 1'b1;
         lnk_upd <= done & (done_cls == CLS_LINK);   // Never forwarded
      end

   always_ff @(posedge clk)
   begin
      if (done && (done_cls == CLS_REQ))
         umi_req_out <= lumi_pkt_t'(shift_nxt);
      if (done && (done_cls == CLS_RESP))
         umi_resp_out <= lumi_pkt_t'(shift_nxt);
      if (done && (done_cls == CLS_LINK))
         lnk_cmd <= shift_nxt[LUMI_CW-1:0];
   end

   // Relies on the arbiter honoring hold
   a_req_stable: assert property (@(posedge clk) disable iff (!nreset)
      umi_req_out_valid && !umi_req_out_ready |=>
         umi_req_out_valid && $stable(umi_req_out));
   a_resp_stable: assert property (@(posedge clk) disable iff (!nreset)
      umi_resp_out_valid && !umi_resp_out_ready |=>
         umi_resp_out_valid && $stable(umi_resp_out));

endmodule

`default_nettype wire

// File: lumi_rx_credit.sv
// Local credit counters for drained queue beats and capture of remote credit updates
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_credit
   import lumi_pkg::*;
   (
      input  wire                    clk,
      input  wire                    nreset,
      input  wire                    csr_en,
      input  wire [LUMI_CRDT_W-1:0]  csr_crdt_req_init,
      input  wire [LUMI_CRDT_W-1:0]  csr_crdt_resp_init,
      input  wire                    req_beat_rd,
      input  wire                    resp_beat_rd,
      input  wire                    lnk_upd,
      input  wire [LUMI_CW-1:0]      lnk_cmd,
      output logic [LUMI_CRDT_W-1:0] loc_crdt_req,
      output logic [LUMI_CRDT_W-1:0] loc_crdt_resp,
      output logic [LUMI_CRDT_W-1:0] rmt_crdt_req,
      output logic [LUMI_CRDT_W-1:0] rmt_crdt_resp
   );

   logic [7:0] subtype;
   logic       upd_req;
   logic       upd_resp;

   // ##############################
   // Local counters
   // ##############################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         loc_crdt_req  <= '0;
         loc_crdt_resp <= '0;
      end
      else if (!csr_en)
      begin
         loc_crdt_req  <= csr_crdt_req_init;   // Preload while disabled
         loc_crdt_resp <= csr_crdt_resp_init;
      end
      else
      begin
         if (req_beat_rd)
            loc_crdt_req <= loc_crdt_req + 1'b1;
         if (resp_beat_rd)
            loc_crdt_resp <= loc_crdt_resp + 1'b1;
      end

   // ##############################
   // Remote credits
   // ##############################
   assign subtype  = lnk_cmd[15:8];
   assign upd_req  = lnk_upd & ((subtype == LUMI_SUB_REQ_A) | (subtype == LUMI_SUB_REQ_B));
   assign upd_resp = lnk_upd & ((subtype == LUMI_SUB_RESP_A) | (subtype == LUMI_SUB_RESP_B));

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         rmt_crdt_req  <= '0;
         rmt_crdt_resp <= '0;
      end
      else
      begin
         if (upd_req)
            rmt_crdt_req <= lnk_cmd[31:16];   // Credit value field
         if (upd_resp)
            rmt_crdt_resp <= lnk_cmd[31:16];
      end

endmodule

`default_nettype wire

// File: lumi_rx_fifo.sv
// Show-ahead beat queue; one instance each for request, response and link traffic
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_fifo
   import lumi_pkg::*;
   #(parameter int DEPTH = 4)
   (
      input  wire                    clk,
      input  wire                    nreset,
      input  wire                    wr_en,
      input  wire [LUMI_BEAT_W-1:0]  wr_din,
      input  wire                    rd_en,
      output logic [LUMI_BEAT_W-1:0] rd_dout,
      output logic                   empty,
      output logic                   full
   );

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [LUMI_BEAT_W-1:0] mem [DEPTH];
   logic [PW-1:0]          wr_ptr;
   logic [PW-1:0]          rd_ptr;
   logic [PW:0]            count;   // Fill level
   logic                   wr_ok;
   logic                   rd_ok;

   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;
   assign empty = (count == '0);
   assign full  = (int'(count) == DEPTH);

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;   // Circular
         if (rd_ok)
            rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end

   always_ff @(posedge clk)
      if (wr_ok)
         mem[wr_ptr] <= wr_din;

   // Head word visible without a read cycle
   assign rd_dout = mem[rd_ptr];

   // Sender must honor credits, reader must honor empty
   a_no_overflow: assert property (@(posedge clk) disable iff (!nreset) wr_en |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!nreset) rd_en |-> !empty);

endmodule

`default_nettype wire

// File: lumi_rx_sampler.sv
// Input stage of the receiver; samples phy beats and steers each one to its class queue
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_sampler
   import lumi_pkg::*;
   (
      input  wire                   clk,
      input  wire                   nreset,
      input  wire [LUMI_BEAT_W-1:0] phy_rxdata,
      input  wire                   phy_rxvld,
      output logic [LUMI_BEAT_W-1:0] wr_data,   // Shared by all queues
      output logic                  req_wr,
      output logic                  resp_wr,
      output logic                  lnk_wr
   );

   logic        rx_vld;      // Registered strobe
   logic [2:0]  cnt;         // Beat within packet, 0 at start
   logic [2:0]  beats_q;     // Beat count of current packet
   lumi_class_e cls_q;       // Class of current packet
   logic        sop;
   lumi_class_e cls;
   logic [2:0]  beats;

   // ##############################
   // Sampling
   // ##############################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         rx_vld <= 1'b0;
      else
         rx_vld <= phy_rxvld;

   always_ff @(posedge clk)
      wr_data <= phy_rxdata;   // Payload only

   // ##############################
   // Packet tracking
   // ##############################
   assign sop   = rx_vld & (cnt == 3'd0);
   assign cls   = sop ? lumi_pkt_class(wr_data) : cls_q;   // Decode head beat directly
   assign beats = sop ? lumi_pkt_beats(wr_data) : beats_q;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         cnt     <= 3'd0;
         beats_q <= 3'd0;
         cls_q   <= CLS_NONE;
      end
      else if (rx_vld)
      begin
         if (sop)
         begin
            cls_q   <= cls;   // Held for the rest of the packet
            beats_q <= beats;
         end
         cnt <= (cnt + 3'd1 >= beats) ? 3'd0 : cnt + 3'd1;   // Wrap on last beat
      end

   // Queue strobes, CLS_NONE goes nowhere
   assign req_wr  = rx_vld & (cls == CLS_REQ);
   assign resp_wr = rx_vld & (cls == CLS_RESP);
   assign lnk_wr  = rx_vld & (cls == CLS_LINK);

   a_cnt_range: assert property (@(posedge clk) disable iff (!nreset)
      (cnt != 3'd0) |-> (cnt < beats_q));

endmodule

`default_nettype wire

// File: lumi_rx_top.sv
// Link receiver top level; wires sampler, queues, arbiter, assembler and credit block
`timescale 1ns/10ps
`default_nettype none

module lumi_rx_top
   import lumi_pkg::*;
   #(
      parameter int REQ_DEPTH  = 64,   // Request beats
      parameter int RESP_DEPTH = 64,   // Response beats
      parameter int LNK_DEPTH  = 4     // Link beats, no flow control
   )
   (
      input  wire                    clk,
      input  wire                    nreset,
      input  wire                    csr_en,
      input  wire [LUMI_CRDT_W-1:0]  csr_crdt_req_init,
      input  wire [LUMI_CRDT_W-1:0]  csr_crdt_resp_init,
      input  wire [LUMI_BEAT_W-1:0]  phy_rxdata,
      input  wire                    phy_rxvld,
      input  wire                    umi_req_out_ready,
      input  wire                    umi_resp_out_ready,
      output lumi_pkt_t              umi_req_out,
      output logic                   umi_req_out_valid,
      output lumi_pkt_t              umi_resp_out,
      output logic                   umi_resp_out_valid,
      output logic [LUMI_CRDT_W-1:0] loc_crdt_req,
      output logic [LUMI_CRDT_W-1:0] loc_crdt_resp,
      output logic [LUMI_CRDT_W-1:0] rmt_crdt_req,
      output logic [LUMI_CRDT_W-1:0] rmt_crdt_resp
   );

   // Sampler to queues
   logic [LUMI_BEAT_W-1:0] wr_data;
   logic                   req_wr;
   logic                   resp_wr;
   logic                   lnk_wr;
   // Queues to arbiter
   logic                   req_empty;
   logic                   resp_empty;
   logic                   lnk_empty;
   logic [LUMI_BEAT_W-1:0] req_dout;
   logic [LUMI_BEAT_W-1:0] resp_dout;
   logic [LUMI_BEAT_W-1:0] lnk_dout;
   logic                   req_rd;
   logic                   resp_rd;
   logic                   lnk_rd;
   // Arbiter to assembler and credits
   logic                   beat_rd;
   logic [LUMI_BEAT_W-1:0] beat_data;
   logic [2:0]             beat_idx;
   logic                   beat_last;
   logic                   hold;
   logic                   req_beat_rd;
   logic                   resp_beat_rd;
   logic                   lnk_upd;
   logic [LUMI_CW-1:0]     lnk_cmd;

   // ##############################
   // Input and queues
   // ##############################
   lumi_rx_sampler i_sampler (.*);   // Names match one to one

   lumi_rx_fifo #(.DEPTH(REQ_DEPTH)) i_req_fifo (
      .clk     (clk),
      .nreset  (nreset),
      .wr_en   (req_wr),
      .wr_din  (wr_data),
      .rd_en   (req_rd),
      .rd_dout (req_dout),
      .empty   (req_empty),
      .full    ()              // Credits prevent overflow
   );

   lumi_rx_fifo #(.DEPTH(RESP_DEPTH)) i_resp_fifo (
      .clk     (clk),
      .nreset  (nreset),
      .wr_en   (resp_wr),
      .wr_din  (wr_data),
      .rd_en   (resp_rd),
      .rd_dout (resp_dout),
      .empty   (resp_empty),
      .full    ()
   );

   lumi_rx_fifo #(.DEPTH(LNK_DEPTH)) i_lnk_fifo (
      .clk     (clk),
      .nreset  (nreset),
      .wr_en   (lnk_wr),
      .wr_din  (wr_data),
      .rd_en   (lnk_rd),
      .rd_dout (lnk_dout),
      .empty   (lnk_empty),
      .full    ()
   );

   // ##############################
   // Shared reassembly path
   // ##############################
   lumi_rx_arbiter i_arbiter (.*);

   lumi_rx_assembler i_assembler (.*);

   lumi_rx_credit i_credit (.*);

endmodule

`default_nettype wire

// File: tb_lumi_rx.sv
// Self-checking testbench for the link receiver; run lumi_rx_top through routing, stall and credits
`timescale 1ns/10ps
`default_nettype none

module tb_lumi_rx
   import lumi_pkg::*;
   ();

   localparam int N_REQ      = 24;   // Request-only packets
   localparam int N_MIX      = 30;   // Mixed request/response packets
   localparam int N_BP       = 40;   // Mixed packets under back-pressure
   localparam int N_LNK      = 8;    // Credit updates
   localparam int N_INV      = 12;   // Invalid-opcode beats
   localparam int FLOW_LIMIT = 56;   // Beats in flight per class below the 64-deep queue
   localparam int LNK_WAIT   = 16;   // Cycles allowed for one credit update
   localparam int MAX_BEATS  = 5 * (N_REQ + N_MIX + N_BP + N_INV / 3) + N_LNK + 2 + N_INV;
   localparam int TIMEOUT    = 8 * MAX_BEATS + 200;

   // ##############################
   // DUT signals
   // ##############################
   logic                   clk = 1'b0;
   logic                   nreset;
   logic                   csr_en;
   logic [LUMI_CRDT_W-1:0] csr_crdt_req_init;
   logic [LUMI_CRDT_W-1:0] csr_crdt_resp_init;
   logic [LUMI_BEAT_W-1:0] phy_rxdata = '0;
   logic                   phy_rxvld = 1'b0;
   logic                   umi_req_out_ready = 1'b1;
   logic                   umi_resp_out_ready = 1'b1;
   lumi_pkt_t              umi_req_out;
   logic                   umi_req_out_valid;
   lumi_pkt_t              umi_resp_out;
   logic                   umi_resp_out_valid;
   logic [LUMI_CRDT_W-1:0] loc_crdt_req;
   logic [LUMI_CRDT_W-1:0] loc_crdt_resp;
   logic [LUMI_CRDT_W-1:0] rmt_crdt_req;
   logic [LUMI_CRDT_W-1:0] rmt_crdt_resp;

   // Scoreboard and bookkeeping
   lumi_pkt_t              exp_req[$];
   lumi_pkt_t              exp_resp[$];
   logic [LUMI_BEAT_W-1:0] phy_q[$];       // Beats waiting for the phy driver
   lumi_pkt_t              mon_pkt;
   logic [31:0]            rng = 32'd54;
   logic [31:0]            bp_rng = 32'd54;   // Separate stream for ready
   logic                   bp_en = 1'b0;
   logic [15:0]            exp_rmt_req = '0;
   logic [15:0]            exp_rmt_resp = '0;
   int                     req_sent = 0;      // Beats sent since csr_en high
   int                     resp_sent = 0;
   int                     req_done = 0;      // Beats of accepted packets
   int                     resp_done = 0;
   int                     checks = 0;
   int                     errors = 0;
   int                     err_mark = 0;
   int                     tests = 0;
   int                     cycles = 0;

   lumi_rx_top i_dut (.*);

   always #4 clk = ~clk;   // 8 ns period

   // ##############################
   // Helpers
   // ##############################
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   task automatic rand_word(output logic [31:0] w);
      rng = xorshift(rng);
      w   = rng;
   endtask

   // Link beats per opcode
   function automatic int beats_of(input logic [3:0] op);
      case (op)
         OP_READ_REQ, OP_WRITE_RESP:                return 3;   // Header only
         OP_WRITE_REQ, OP_POSTED_REQ, OP_READ_RESP: return 5;
         default:                                   return 1;
      endcase
   endfunction

   task automatic note_failure(input string what);
      errors++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   task automatic check_true(input bit cond, input string what);
      checks++;
      a_true: assert (cond) else note_failure(what);
   endtask

   task automatic check_eq(input string name, input logic [159:0] got, input logic [159:0] exp);
      checks++;
      a_eq: assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "bad",
               errors - err_mark);
      err_mark = errors;
   endtask

   // Build one packet, queue its beats and its expected output
   task automatic send_packet(input lumi_opcode_e op);
      lumi_pkt_t   pkt;
      logic [31:0] r;
      int          n;
      bit          is_req;
      n      = beats_of(op);
      is_req = (op == OP_READ_REQ) || (op == OP_WRITE_REQ) || (op == OP_POSTED_REQ);
      if (is_req)   // Stay inside queue credit
         while (req_sent - req_done + n > FLOW_LIMIT) @(posedge clk);
      else
         while (resp_sent - resp_done + n > FLOW_LIMIT) @(posedge clk);
      pkt = '0;     // No data on 3-beat packets
      rand_word(r);
      pkt.cmd = {r[31:4], op};
      rand_word(r);
      pkt.dstaddr = r;
      rand_word(r);
      pkt.srcaddr = r;
      if (n == 5)
      begin
         rand_word(r);
         pkt.data[31:0] = r;
         rand_word(r);
         pkt.data[63:32] = r;
      end
      if (is_req)
      begin
         exp_req.push_back(pkt);
         req_sent += n;
      end
      else
      begin
         exp_resp.push_back(pkt);
         resp_sent += n;
      end
      // Arrival order cmd, dst, src, data low, data high
      phy_q.push_back(pkt.cmd);
      phy_q.push_back(pkt.dstaddr);
      phy_q.push_back(pkt.srcaddr);
      if (n == 5)
      begin
         phy_q.push_back(pkt.data[31:0]);
         phy_q.push_back(pkt.data[63:32]);
      end
   endtask

   task automatic send_random(input bit want_req);
      logic [31:0]  r;
      lumi_opcode_e op;
      rand_word(r);
      if (want_req)
         case (r % 3)
            0:       op = OP_READ_REQ;
            1:       op = OP_WRITE_REQ;
            default: op = OP_POSTED_REQ;
         endcase
      else
         op = r[7] ? OP_READ_RESP : OP_WRITE_RESP;
      send_packet(op);
   endtask

   task automatic send_invalid();
      logic [31:0] r;
      logic [3:0]  nib;
      rand_word(r);
      nib = r[3:0];
      if (nib >= 4'd1 && nib <= 4'd6)
         nib = nib + 4'd6;   // Push into 7..12
      phy_q.push_back({r[31:4], nib});
   endtask

   task automatic send_link(input logic [7:0] sub, input logic [15:0] val);
      logic [31:0] r;
      rand_word(r);
      phy_q.push_back({val, sub, r[7:4], OP_LINK});
   endtask

   task automatic wait_drain();
      while (phy_q.size() != 0 || exp_req.size() != 0 || exp_resp.size() != 0)
         @(posedge clk);
   endtask

   // ##############################
   // Drivers and monitors
   // ##############################
   always @(posedge clk)
   begin
      #1;
      if (phy_q.size() != 0)
      begin
         phy_rxdata = phy_q.pop_front();
         phy_rxvld  = 1'b1;
      end
      else
         phy_rxvld = 1'b0;
   end

   always @(posedge clk)
   begin
      #1;
      bp_rng             = xorshift(bp_rng);
      umi_req_out_ready  = !bp_en | bp_rng[4];   // About half low under stall
      umi_resp_out_ready = !bp_en | bp_rng[9];
   end

   always @(posedge clk)
      if (nreset)
      begin
         if (umi_req_out_valid && umi_req_out_ready)
         begin
            check_true(exp_req.size() != 0, "request port delivered a packet nobody sent");
            if (exp_req.size() != 0)
            begin
               mon_pkt = exp_req.pop_front();
               check_eq("umi_req_out", umi_req_out, mon_pkt);
               req_done += beats_of(mon_pkt.cmd[3:0]);
            end
         end
         if (umi_resp_out_valid && umi_resp_out_ready)
         begin
            check_true(exp_resp.size() != 0, "response port delivered a packet nobody sent");
            if (exp_resp.size() != 0)
            begin
               mon_pkt = exp_resp.pop_front();
               check_eq("umi_resp_out", umi_resp_out, mon_pkt);
               resp_done += beats_of(mon_pkt.cmd[3:0]);
            end
         end
      end

   a_req_hold: assert property (@(posedge clk) disable iff (!nreset)
      umi_req_out_valid && !umi_req_out_ready |=> umi_req_out_valid && $stable(umi_req_out))
      else note_failure("request output dropped or changed before it was accepted");
   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      umi_resp_out_valid && !umi_resp_out_ready |=> umi_resp_out_valid && $stable(umi_resp_out))
      else note_failure("response output dropped or changed before it was accepted");

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= TIMEOUT)
      begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Regression failed");
         $finish;
      end
   end

   // ##############################
   // Test sequence
   // ##############################
   initial
   begin
      logic [31:0] r;
      logic [15:0] v;
      logic [7:0]  sub;
      nreset = 1'b0;
      csr_en = 1'b0;
      rand_word(r);
      csr_crdt_req_init  = r[15:0];
      csr_crdt_resp_init = r[31:16];
      repeat (8) @(posedge clk);
      check_eq("umi_req_out_valid", umi_req_out_valid, 1'b0);
      check_eq("umi_resp_out_valid", umi_resp_out_valid, 1'b0);
      check_eq("loc_crdt_req", loc_crdt_req, 16'h0);
      check_eq("loc_crdt_resp", loc_crdt_resp, 16'h0);
      check_eq("rmt_crdt_req", rmt_crdt_req, 16'h0);
      check_eq("rmt_crdt_resp", rmt_crdt_resp, 16'h0);
      #1 nreset = 1'b1;
      end_test("reset");

      repeat (2) @(posedge clk);   // Preload lands one edge after release
      check_eq("loc_crdt_req", loc_crdt_req, csr_crdt_req_init);
      check_eq("loc_crdt_resp", loc_crdt_resp, csr_crdt_resp_init);
      end_test("credit_preload");
      #1 csr_en = 1'b1;

      for (int i = 0; i < N_REQ; i++)
         send_random(1'b1);
      wait_drain();
      end_test("request_routing");

      for (int i = 0; i < N_MIX; i++)
      begin
         rand_word(r);
         send_random(r[2]);   // Responses mixed with requests
      end
      wait_drain();
      end_test("response_routing");

      bp_en = 1'b1;
      for (int i = 0; i < N_BP; i++)
      begin
         rand_word(r);
         send_random(r[5]);
      end
      wait_drain();
      bp_en = 1'b0;
      end_test("back_pressure");

      // One update at a time with a bounded wait for its register
      for (int i = 0; i < N_LNK; i++)
      begin
         case (i % 4)
            0:       sub = 8'h01;
            1:       sub = 8'h02;
            2:       sub = 8'h11;
            default: sub = 8'h12;
         endcase
         rand_word(r);
         v = r[15:0];
         if (sub[4])
         begin
            if (v == exp_rmt_resp)
               v = ~v;
            exp_rmt_resp = v;
            send_link(sub, v);
            for (int k = 0; k < LNK_WAIT && rmt_crdt_resp !== v; k++)
               @(posedge clk);
         end
         else
         begin
            if (v == exp_rmt_req)
               v = ~v;
            exp_rmt_req = v;
            send_link(sub, v);
            for (int k = 0; k < LNK_WAIT && rmt_crdt_req !== v; k++)
               @(posedge clk);
         end
         check_eq("rmt_crdt_req", rmt_crdt_req, exp_rmt_req);
         check_eq("rmt_crdt_resp", rmt_crdt_resp, exp_rmt_resp);
      end
      // Unknown subtype followed by a marker update
      rand_word(r);
      v = (r[15:0] == exp_rmt_req) ? ~r[15:0] : r[15:0];
      send_link(8'h33, v);
      v = (r[31:16] == exp_rmt_resp) ? ~r[31:16] : r[31:16];
      exp_rmt_resp = v;
      send_link(8'h11, v);
      for (int k = 0; k < LNK_WAIT && rmt_crdt_resp !== v; k++)
         @(posedge clk);
      check_eq("rmt_crdt_req", rmt_crdt_req, exp_rmt_req);
      check_eq("rmt_crdt_resp", rmt_crdt_resp, exp_rmt_resp);
      end_test("link_credits");

      for (int i = 0; i < N_INV; i++)
      begin
         send_invalid();
         if (i % 3 == 0)
            send_random(1'b1);   // Real traffic around the junk
      end
      wait_drain();
      check_eq("rmt_crdt_req", rmt_crdt_req, exp_rmt_req);
      check_eq("rmt_crdt_resp", rmt_crdt_resp, exp_rmt_resp);
      end_test("invalid_opcodes");

      @(posedge clk);
      check_eq("loc_crdt_req", loc_crdt_req, csr_crdt_req_init + 16'(req_sent));
      check_eq("loc_crdt_resp", loc_crdt_resp, csr_crdt_resp_init + 16'(resp_sent));
      end_test("local_credits");

      $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire
